// ==== list.f ====
+incdir+logic
+incdir+test
logic/cpu_pkg.sv
logic/hazard_if.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/hazard_unit.sv
logic/pipeline_cpu.sv
test/tb_pipeline_cpu.sv

// ==== logic/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

//////////////////////////////
// Memory sizes

// Instruction RAM depth in words
`define CPU_IMEM_DEPTH 256

// Data RAM depth in words
`define CPU_DMEM_DEPTH 256

//////////////////////////////
// Reset state

// First fetch address
`define CPU_RESET_PC 32'h0000_0000

`endif

// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [2:0]  alu_sel_t;
	typedef logic [1:0]  fwd_sel_t;

	// Primary opcodes
	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_J     = 6'h02;
	localparam opcode_t OP_BEQ   = 6'h04;
	localparam opcode_t OP_ADDI  = 6'h08;
	localparam opcode_t OP_LW    = 6'h23;
	localparam opcode_t OP_SW    = 6'h2b;

	// R-type function codes
	localparam funct_t FN_ADD = 6'h20;
	localparam funct_t FN_SUB = 6'h22;
	localparam funct_t FN_AND = 6'h24;
	localparam funct_t FN_OR  = 6'h25;
	localparam funct_t FN_SLT = 6'h2a;

	// ALU operations
	localparam alu_sel_t ALU_ADD = 3'd0;
	localparam alu_sel_t ALU_SUB = 3'd1;
	localparam alu_sel_t ALU_AND = 3'd2;
	localparam alu_sel_t ALU_OR  = 3'd3;
	localparam alu_sel_t ALU_SLT = 3'd4;

	// Operand sources in execute
	localparam fwd_sel_t FWD_RF    = 2'd0;
	localparam fwd_sel_t FWD_EXMEM = 2'd1;
	localparam fwd_sel_t FWD_MEMWB = 2'd2;

endpackage

// ==== logic/decode_stage.sv ====
module decode_stage
	import cpu_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  word_t     i_instr,
	input  word_t     i_pc_plus4,
	input  logic      i_valid,
	input  logic      i_branch,
	input  logic      i_wb_en,
	input  reg_addr_t i_wb_reg,
	input  word_t     i_wb_data,
	hazard_if.decode  hz,
	output logic      o_jump,
	output word_t     o_jump_target,
	output word_t     o_rs_data,
	output word_t     o_rt_data,
	output word_t     o_imm,
	output reg_addr_t o_rt,
	output reg_addr_t o_rd,
	output alu_sel_t  o_alu_sel,
	output logic      o_reg_write,
	output logic      o_mem_read,
	output logic      o_mem_write,
	output logic      o_branch_op,
	output logic      o_alu_src,
	output logic      o_reg_dst,
	output word_t     o_pc_plus4
);

	opcode_t   opcode;
	funct_t    funct;
	reg_addr_t rs, rt, rd;
	word_t     imm;
	alu_sel_t  alu_sel;
	logic      uses_rs, uses_rt, is_jump;
	logic      reg_write, mem_read, mem_write, branch_op, alu_src, reg_dst;
	reg_addr_t idex_rs;
	word_t     regs [32];

	assign opcode = i_instr[31:26];
	assign rs     = i_instr[25:21];
	assign rt     = i_instr[20:16];
	assign rd     = i_instr[15:11];
	assign funct  = i_instr[5:0];
	assign imm    = {{16{i_instr[15]}}, i_instr[15:0]};

	//////////////////////////////
	// Control decode

	always_comb
	begin
		{uses_rs, uses_rt, is_jump} = '0;
		{reg_write, mem_read, mem_write, branch_op, alu_src, reg_dst} = '0;
		alu_sel = ALU_ADD;
		if (i_valid)
		begin
			case (opcode)
				OP_RTYPE:
				begin
					{uses_rs, uses_rt, reg_write, reg_dst} = '1;
					case (funct)
						FN_SUB:  alu_sel = ALU_SUB;
						FN_AND:  alu_sel = ALU_AND;
						FN_OR:   alu_sel = ALU_OR;
						FN_SLT:  alu_sel = ALU_SLT;
						default: alu_sel = ALU_ADD;
					endcase
				end
				OP_ADDI: {uses_rs, reg_write, alu_src} = '1;
				OP_LW:   {uses_rs, reg_write, mem_read, alu_src} = '1;
				OP_SW:   {uses_rs, uses_rt, mem_write, alu_src} = '1;
				OP_BEQ:
				begin
					{uses_rs, uses_rt, branch_op} = '1;
					alu_sel = ALU_SUB;
				end
				OP_J:    is_jump = 1'b1;
				default: ;
			endcase
		end
	end

	assign o_jump        = is_jump;
	assign o_jump_target = {i_pc_plus4[31:28], i_instr[25:0], 2'b00};

	// Unused fields read as r0 so they never match a load
	assign hz.ifid_rs = uses_rs ? rs : 5'd0;
	assign hz.ifid_rt = uses_rt ? rt : 5'd0;

	//////////////////////////////
	// Register file

	always_ff @(posedge i_clk)
	begin
		if (i_wb_en)
			regs[i_wb_reg] <= i_wb_data;
	end

	// Same-cycle writeback is bypassed
	function automatic word_t read_reg(reg_addr_t r);
		if (r == 5'd0)
			return '0;
		else if (i_wb_en && i_wb_reg == r)
			return i_wb_data;
		else
			return regs[r];
	endfunction

	//////////////////////////////
	// ID/EX register

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n || hz.stall || i_branch)
			{o_reg_write, o_mem_read, o_mem_write, o_branch_op, o_alu_src, o_reg_dst} <= '0;
		else
			{o_reg_write, o_mem_read, o_mem_write, o_branch_op, o_alu_src, o_reg_dst} <=
				{reg_write, mem_read, mem_write, branch_op, alu_src, reg_dst};
	end

	always_ff @(posedge i_clk)
	begin
		o_rs_data  <= read_reg(rs);
		o_rt_data  <= read_reg(rt);
		o_imm      <= imm;
		idex_rs    <= rs;
		o_rt       <= rt;
		o_rd       <= rd;
		o_alu_sel  <= alu_sel;
		o_pc_plus4 <= i_pc_plus4;
	end

	assign hz.idex_rs   = idex_rs;
	assign hz.idex_rt   = o_rt;
	assign hz.idex_load = o_mem_read;

	// Writeback never targets entry 0
	a_r0_never_written: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_wb_en |-> (i_wb_reg != 5'd0));

endmodule

// ==== logic/execute_stage.sv ====
module execute_stage
	import cpu_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  word_t     i_rs_data,
	input  word_t     i_rt_data,
	input  word_t     i_imm,
	input  reg_addr_t i_rt,
	input  reg_addr_t i_rd,
	input  alu_sel_t  i_alu_sel,
	input  logic      i_reg_write,
	input  logic      i_mem_read,
	input  logic      i_mem_write,
	input  logic      i_branch_op,
	input  logic      i_alu_src,
	input  logic      i_reg_dst,
	input  word_t     i_pc_plus4,
	input  logic      i_branch,
	input  word_t     i_fwd_mem_data,
	input  word_t     i_wb_data,
	hazard_if.execute hz,
	output word_t     o_result,
	output word_t     o_store_data,
	output logic      o_zero,
	output word_t     o_branch_target,
	output reg_addr_t o_dest,
	output logic      o_reg_write,
	output logic      o_mem_read,
	output logic      o_mem_write,
	output logic      o_branch_op
);

	word_t op_a, fwd_b, op_b, alu_out;

	// Forwarding muxes
	always_comb
	begin
		case (hz.forward_a)
			FWD_EXMEM: op_a = i_fwd_mem_data;
			FWD_MEMWB: op_a = i_wb_data;
			default:   op_a = i_rs_data;
		endcase
		case (hz.forward_b)
			FWD_EXMEM: fwd_b = i_fwd_mem_data;
			FWD_MEMWB: fwd_b = i_wb_data;
			default:   fwd_b = i_rt_data;
		endcase
	end

	assign op_b = i_alu_src ? i_imm : fwd_b;

	always_comb
	begin
		case (i_alu_sel)
			ALU_SUB: alu_out = op_a - op_b;
			ALU_AND: alu_out = op_a & op_b;
			ALU_OR:  alu_out = op_a | op_b;
			ALU_SLT: alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
			default: alu_out = op_a + op_b;
		endcase
	end

	//////////////////////////////
	// EX/MEM register

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n || i_branch)
			{o_reg_write, o_mem_read, o_mem_write, o_branch_op} <= '0;
		else
			{o_reg_write, o_mem_read, o_mem_write, o_branch_op} <=
				{i_reg_write, i_mem_read, i_mem_write, i_branch_op};
	end

	always_ff @(posedge i_clk)
	begin
		o_result        <= alu_out;
		o_store_data    <= fwd_b;
		o_zero          <= (alu_out == '0);
		o_branch_target <= i_pc_plus4 + (i_imm << 2);
		o_dest          <= i_reg_dst ? i_rd : i_rt;
	end

	assign hz.exmem_rd = o_dest;
	assign hz.exmem_we = o_reg_write;

endmodule

// ==== logic/fetch_stage.sv ====
`include "cpu_cfg.svh"

module fetch_stage
	import cpu_pkg::*;
(
	input  logic  i_clk,
	input  logic  i_rst_n,
	input  logic  i_imem_we,
	input  word_t i_imem_addr,
	input  word_t i_imem_data,
	input  logic  i_stall,
	input  logic  i_jump,
	input  word_t i_jump_target,
	input  logic  i_branch,
	input  word_t i_branch_target,
	output word_t o_instr,
	output word_t o_pc_plus4,
	output logic  o_valid
);

	localparam int IMEM_AW = $clog2(`CPU_IMEM_DEPTH);

	word_t imem [`CPU_IMEM_DEPTH];
	word_t pc;
	word_t pc_plus4;
	word_t pc_next;

	assign pc_plus4 = pc + 32'd4;

	// Branch beats jump, stall holds the PC
	always_comb
	begin
		if (i_branch)
			pc_next = i_branch_target;
		else if (i_jump)
			pc_next = i_jump_target;
		else if (i_stall)
			pc_next = pc;
		else
			pc_next = pc_plus4;
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
			pc <= `CPU_RESET_PC;
		else
			pc <= pc_next;
	end

	// Load port, byte address
	always_ff @(posedge i_clk)
	begin
		if (i_imem_we)
			imem[i_imem_addr[IMEM_AW+1:2]] <= i_imem_data;
	end

	//////////////////////////////
	// IF/ID register

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n || i_branch || i_jump)
			o_valid <= 1'b0;
		else if (!i_stall)
			o_valid <= 1'b1;
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_stall)
		begin
			o_instr    <= imem[pc[IMEM_AW+1:2]];
			o_pc_plus4 <= pc_plus4;
		end
	end

endmodule

// ==== logic/hazard_if.sv ====
interface hazard_if
	import cpu_pkg::*;
(
	input logic i_clk,
	input logic i_rst_n
);

	// Sources of the instruction in decode, zero when unused
	reg_addr_t ifid_rs;
	reg_addr_t ifid_rt;

	// Instruction in execute
	reg_addr_t idex_rs;
	reg_addr_t idex_rt;
	logic      idex_load;

	// Older instructions still holding a result
	reg_addr_t exmem_rd;
	logic      exmem_we;
	reg_addr_t memwb_rd;
	logic      memwb_we;

	// Hazard unit decisions
	fwd_sel_t  forward_a;
	fwd_sel_t  forward_b;
	logic      stall;

	modport decode (output ifid_rs, ifid_rt, idex_rs, idex_rt, idex_load, input stall);

	modport execute (output exmem_rd, exmem_we, input forward_a, forward_b);

	modport memory (output memwb_rd, memwb_we);

	modport unit (
		input  i_clk, i_rst_n,
		input  ifid_rs, ifid_rt, idex_rs, idex_rt, idex_load,
		input  exmem_rd, exmem_we, memwb_rd, memwb_we,
		output forward_a, forward_b, stall
	);

endinterface

// ==== logic/hazard_unit.sv ====
module hazard_unit
	import cpu_pkg::*;
(
	hazard_if.unit hz
);

	// Youngest matching producer wins
	function automatic fwd_sel_t pick_fwd(reg_addr_t src);
		if (hz.exmem_we && hz.exmem_rd != 5'd0 && hz.exmem_rd == src)
			return FWD_EXMEM;
		else if (hz.memwb_we && hz.memwb_rd != 5'd0 && hz.memwb_rd == src)
			return FWD_MEMWB;
		else
			return FWD_RF;
	endfunction

	//////////////////////////////
	// Forwarding

	always_comb
	begin
		hz.forward_a = pick_fwd(hz.idex_rs);
		hz.forward_b = pick_fwd(hz.idex_rt);
	end

	//////////////////////////////
	// Load-use detection

	// Load result is not ready until MEM/WB
	always_comb
	begin
		hz.stall = 1'b0;
		if (hz.idex_load && hz.idex_rt != 5'd0)
		begin
			if (hz.idex_rt == hz.ifid_rs || hz.idex_rt == hz.ifid_rt)
				hz.stall = 1'b1;
		end
	end

	// Bubble in ID/EX clears the condition next cycle
	a_stall_one_cycle: assert property (@(posedge hz.i_clk) disable iff (!hz.i_rst_n)
		hz.stall |=> !hz.stall);

endmodule

// ==== logic/memory_stage.sv ====
`include "cpu_cfg.svh"

module memory_stage
	import cpu_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  word_t     i_result,
	input  word_t     i_store_data,
	input  logic      i_zero,
	input  word_t     i_branch_target,
	input  reg_addr_t i_dest,
	input  logic      i_reg_write,
	input  logic      i_mem_read,
	input  logic      i_mem_write,
	input  logic      i_branch_op,
	hazard_if.memory  hz,
	output logic      o_branch,
	output word_t     o_branch_target,
	output word_t     o_fwd_data,
	output logic      o_wb_en,
	output reg_addr_t o_wb_reg,
	output word_t     o_wb_data
);

	localparam int DMEM_AW = $clog2(`CPU_DMEM_DEPTH);

	word_t dmem [`CPU_DMEM_DEPTH];
	word_t load_data;
	word_t wb_result, wb_mem_data;
	logic  wb_load;

	assign load_data = dmem[i_result[DMEM_AW+1:2]];

	always_ff @(posedge i_clk)
	begin
		if (i_mem_write)
			dmem[i_result[DMEM_AW+1:2]] <= i_store_data;
	end

	// beq taken
	assign o_branch        = i_branch_op & i_zero;
	assign o_branch_target = i_branch_target;
	assign o_fwd_data      = i_result;

	//////////////////////////////
	// MEM/WB register

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
			{o_wb_en, wb_load} <= '0;
		else
			{o_wb_en, wb_load} <= {i_reg_write && i_dest != 5'd0, i_mem_read};
	end

	always_ff @(posedge i_clk)
	begin
		o_wb_reg    <= i_dest;
		wb_result   <= i_result;
		wb_mem_data <= load_data;
	end

	assign o_wb_data   = wb_load ? wb_mem_data : wb_result;
	assign hz.memwb_rd = o_wb_reg;
	assign hz.memwb_we = o_wb_en;

	a_word_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_mem_read || i_mem_write) |-> (i_result[1:0] == 2'b00));

endmodule

// ==== logic/pipeline_cpu.sv ====
module pipeline_cpu
	import cpu_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  logic      i_imem_we,
	input  word_t     i_imem_addr,
	input  word_t     i_imem_data,
	output logic      o_wb_valid,
	output reg_addr_t o_wb_reg,
	output word_t     o_wb_data,
	output logic      o_stall,
	output logic      o_flush
);

	// Fetch and redirects
	word_t     if_instr, if_pc_plus4, jump_target, branch_target;
	logic      if_valid, jump, branch;

	// ID/EX bundle
	word_t     id_rs_data, id_rt_data, id_imm, id_pc_plus4;
	reg_addr_t id_rt, id_rd;
	alu_sel_t  id_alu_sel;
	logic      id_reg_write, id_mem_read, id_mem_write, id_branch_op, id_alu_src, id_reg_dst;

	// EX/MEM bundle
	word_t     ex_result, ex_store_data, ex_branch_target;
	reg_addr_t ex_dest;
	logic      ex_zero, ex_reg_write, ex_mem_read, ex_mem_write, ex_branch_op;

	// Writeback
	word_t     fwd_mem_data, wb_data;
	reg_addr_t wb_reg;
	logic      wb_en;

	hazard_if hz_i (.i_clk(i_clk), .i_rst_n(i_rst_n));

	fetch_stage fetch_stage_i (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_imem_we(i_imem_we),
		.i_imem_addr(i_imem_addr), .i_imem_data(i_imem_data), .i_stall(hz_i.stall),
		.i_jump(jump), .i_jump_target(jump_target), .i_branch(branch),
		.i_branch_target(branch_target), .o_instr(if_instr), .o_pc_plus4(if_pc_plus4),
		.o_valid(if_valid));

	decode_stage decode_stage_i (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_instr(if_instr), .i_pc_plus4(if_pc_plus4),
		.i_valid(if_valid), .i_branch(branch), .i_wb_en(wb_en), .i_wb_reg(wb_reg),
		.i_wb_data(wb_data), .hz(hz_i.decode), .o_jump(jump), .o_jump_target(jump_target),
		.o_rs_data(id_rs_data), .o_rt_data(id_rt_data), .o_imm(id_imm), .o_rt(id_rt),
		.o_rd(id_rd), .o_alu_sel(id_alu_sel), .o_reg_write(id_reg_write),
		.o_mem_read(id_mem_read), .o_mem_write(id_mem_write), .o_branch_op(id_branch_op),
		.o_alu_src(id_alu_src), .o_reg_dst(id_reg_dst), .o_pc_plus4(id_pc_plus4));

	execute_stage execute_stage_i (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_rs_data(id_rs_data), .i_rt_data(id_rt_data),
		.i_imm(id_imm), .i_rt(id_rt), .i_rd(id_rd), .i_alu_sel(id_alu_sel),
		.i_reg_write(id_reg_write), .i_mem_read(id_mem_read), .i_mem_write(id_mem_write),
		.i_branch_op(id_branch_op), .i_alu_src(id_alu_src), .i_reg_dst(id_reg_dst),
		.i_pc_plus4(id_pc_plus4), .i_branch(branch), .i_fwd_mem_data(fwd_mem_data),
		.i_wb_data(wb_data), .hz(hz_i.execute), .o_result(ex_result),
		.o_store_data(ex_store_data), .o_zero(ex_zero), .o_branch_target(ex_branch_target),
		.o_dest(ex_dest), .o_reg_write(ex_reg_write), .o_mem_read(ex_mem_read),
		.o_mem_write(ex_mem_write), .o_branch_op(ex_branch_op));

	memory_stage memory_stage_i (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_result(ex_result),
		.i_store_data(ex_store_data), .i_zero(ex_zero), .i_branch_target(ex_branch_target),
		.i_dest(ex_dest), .i_reg_write(ex_reg_write), .i_mem_read(ex_mem_read),
		.i_mem_write(ex_mem_write), .i_branch_op(ex_branch_op), .hz(hz_i.memory),
		.o_branch(branch), .o_branch_target(branch_target), .o_fwd_data(fwd_mem_data),
		.o_wb_en(wb_en), .o_wb_reg(wb_reg), .o_wb_data(wb_data));

	hazard_unit hazard_unit_i (.hz(hz_i.unit));

	assign o_wb_valid = wb_en;
	assign o_wb_reg   = wb_reg;
	assign o_wb_data  = wb_data;

	// A load squashed by a taken branch is not a real bubble
	assign o_stall = hz_i.stall & ~branch;
	assign o_flush = branch | jump;

endmodule

// ==== test/tb_cpu_model.svh ====
`ifndef TB_CPU_MODEL_SVH
`define TB_CPU_MODEL_SVH

//////////////////////////////
// Random source

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] rand16();
	logic [15:0] r;
	logic        fb;
	r = '0;
	for (int i = 0; i < 16; i++)
	begin
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		r = {r[14:0], fb};
	end
	return r;
endfunction

//////////////////////////////
// Instruction encoders

function automatic word_t enc_r(funct_t fn, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
	return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
endfunction

function automatic word_t enc_i(opcode_t op, reg_addr_t rt, reg_addr_t rs, logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic word_t enc_j(int target);
	logic [25:0] t;
	t = target[25:0];
	return {OP_J, t};
endfunction

task automatic emit(word_t w);
	prog[prog_len] = w;
	prog_len++;
endtask

// Last register write, then a jump to itself
task automatic close_program(reg_addr_t rd, reg_addr_t rs);
	emit(enc_i(OP_ADDI, rd, rs, 16'd1));
	emit(enc_j(prog_len));
endtask

//////////////////////////////
// Reference model

// Runs the program one instruction at a time
function automatic void run_model();
	word_t     regs [32];
	word_t     dmem [int];
	word_t     instr, val, a, b, imm;
	reg_addr_t rs, rt, rd, dest, prev_rt;
	logic      uses_rs, uses_rt, we, prev_load;
	int        pc, next, steps;
	exp_reg.delete();
	exp_data.delete();
	exp_stalls = 0;
	exp_flushes = 0;
	for (int i = 0; i < 32; i++)
		regs[i] = '0;
	pc = 0;
	prev_load = 1'b0;
	prev_rt = '0;
	for (steps = 0; steps < 2000; steps++)
	begin
		instr = prog[pc];
		rs = instr[25:21];
		rt = instr[20:16];
		rd = instr[15:11];
		imm = {{16{instr[15]}}, instr[15:0]};
		a = regs[rs];
		b = regs[rt];
		uses_rs = instr[31:26] != OP_J;
		uses_rt = instr[31:26] inside {OP_RTYPE, OP_SW, OP_BEQ};
		if (prev_load && prev_rt != 0 && ((uses_rs && rs == prev_rt) || (uses_rt && rt == prev_rt)))
			exp_stalls++;
		prev_load = 1'b0;
		we = 1'b0;
		dest = rt;
		val = '0;
		next = pc + 1;
		case (instr[31:26])
			OP_RTYPE:
			begin
				we = 1'b1;
				dest = rd;
				case (instr[5:0])
					FN_SUB:  val = a - b;
					FN_AND:  val = a & b;
					FN_OR:   val = a | b;
					FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: val = a + b;
				endcase
			end
			OP_ADDI:
			begin
				we = 1'b1;
				val = a + imm;
			end
			OP_LW:
			begin
				we = 1'b1;
				val = dmem.exists((a + imm) >> 2) ? dmem[(a + imm) >> 2] : '0;
				prev_load = 1'b1;
				prev_rt = rt;
			end
			OP_SW: dmem[(a + imm) >> 2] = b;
			OP_BEQ:
			begin
				if (a == b)
				begin
					next = pc + 1 + int'($signed(imm));
					exp_flushes++;
				end
			end
			default:
			begin
				// Jump, the one to itself closes the program
				exp_flushes++;
				if (int'(instr[25:0]) == pc)
					return;
				next = int'(instr[25:0]);
			end
		endcase
		if (we && dest != 0)
		begin
			regs[dest] = val;
			exp_reg.push_back(dest);
			exp_data.push_back(val);
		end
		pc = next;
	end
endfunction

`endif

// ==== test/tb_pipeline_cpu.sv ====
module tb_pipeline_cpu
	import cpu_pkg::*;
();

	logic      clk, rst_n, imem_we;
	word_t     imem_addr, imem_data;
	logic      o_wb_valid, o_stall, o_flush;
	reg_addr_t o_wb_reg;
	word_t     o_wb_data;

	logic [15:0] lfsr_state = 16'd20;
	word_t       prog [256];
	int          prog_len;
	reg_addr_t   exp_reg [$];
	word_t       exp_data [$];
	reg_addr_t   got_reg [$];
	word_t       got_data [$];
	int          exp_stalls, exp_flushes, stall_count, flush_count;
	int          errors, test_errors, tests_run, tests_failed;
	int          cycle_count;
	int          budget = 20;
	logic        monitor_on;

	`include "tb_cpu_model.svh"

	pipeline_cpu pipeline_cpu_i (
		.i_clk(clk), .i_rst_n(rst_n), .i_imem_we(imem_we), .i_imem_addr(imem_addr),
		.i_imem_data(imem_data), .o_wb_valid(o_wb_valid), .o_wb_reg(o_wb_reg),
		.o_wb_data(o_wb_data), .o_stall(o_stall), .o_flush(o_flush));

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_value(string what, word_t expected, word_t actual);
		if (expected !== actual)
		begin
			errors++;
			test_errors++;
			$display("mismatch %s expected %h actual %h", what, expected, actual);
		end
	endtask

	// Retire trace and hazard counts up to the last expected writeback
	always @(negedge clk)
	begin
		if (monitor_on)
		begin
			if (o_wb_valid)
			begin
				got_reg.push_back(o_wb_reg);
				got_data.push_back(o_wb_data);
			end
			if (got_reg.size() < exp_reg.size())
			begin
				if (o_stall)
					stall_count++;
				if (o_flush)
					flush_count++;
			end
		end
	end

	initial
	begin
		cycle_count = 0;
		while (cycle_count <= budget)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: no final writeback after %0d cycles", cycle_count);
		$display("Some tests failed");
		$finish;
	end

	task automatic run_program(string name);
		budget += 40 * prog_len;
		test_errors = 0;
		@(posedge clk);
		rst_n <= 1'b0;
		for (int i = 0; i < prog_len; i++)
		begin
			@(posedge clk);
			imem_we   <= 1'b1;
			imem_addr <= i * 4;
			imem_data <= prog[i];
		end
		@(posedge clk);
		imem_we <= 1'b0;
		repeat (5) @(posedge clk);
		run_model();
		got_reg.delete();
		got_data.delete();
		stall_count = 0;
		flush_count = 0;
		monitor_on = 1'b1;
		rst_n <= 1'b1;
		while (got_reg.size() < exp_reg.size())
			@(posedge clk);
		repeat (10) @(posedge clk);
		monitor_on = 1'b0;
		check_value({name, " writebacks"}, exp_reg.size(), got_reg.size());
		for (int i = 0; i < exp_reg.size() && i < got_reg.size(); i++)
		begin
			check_value($sformatf("%s wb%0d reg", name, i), exp_reg[i], got_reg[i]);
			check_value($sformatf("%s wb%0d data", name, i), exp_data[i], got_data[i]);
		end
		check_value({name, " stalls"}, exp_stalls, stall_count);
		check_value({name, " flushes"}, exp_flushes, flush_count);
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		$display("%s: %0d writebacks, %0d stalls, %0d flushes, %s", name, got_reg.size(),
			stall_count, flush_count, (test_errors == 0) ? "ok" : "FAILED");
		prog_len = 0;
	endtask

	initial
	begin
		rst_n = 1'b0;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_data = '0;
		monitor_on = 1'b0;
		{errors, tests_run, tests_failed, prog_len} = '0;

		// Dependent ALU chain
		emit(enc_i(OP_ADDI, 5'd1, 5'd0, rand16()));
		emit(enc_i(OP_ADDI, 5'd2, 5'd0, rand16()));
		emit(enc_r(FN_ADD, 5'd3, 5'd1, 5'd2));
		emit(enc_r(FN_SUB, 5'd4, 5'd3, 5'd1));
		emit(enc_r(FN_AND, 5'd5, 5'd4, 5'd3));
		emit(enc_r(FN_OR, 5'd6, 5'd5, 5'd2));
		emit(enc_r(FN_SLT, 5'd7, 5'd6, 5'd4));
		emit(enc_r(FN_SLT, 5'd8, 5'd4, 5'd6));
		close_program(5'd10, 5'd7);
		run_program("alu_chain");

		// Stores followed by loads and their uses
		emit(enc_i(OP_ADDI, 5'd1, 5'd0, rand16()));
		emit(enc_i(OP_ADDI, 5'd2, 5'd0, rand16()));
		emit(enc_i(OP_SW, 5'd1, 5'd0, 16'd8));
		emit(enc_i(OP_SW, 5'd2, 5'd0, 16'd12));
		emit(enc_i(OP_LW, 5'd3, 5'd0, 16'd8));
		emit(enc_r(FN_ADD, 5'd4, 5'd3, 5'd1));
		emit(enc_i(OP_LW, 5'd5, 5'd0, 16'd12));
		emit(enc_i(OP_SW, 5'd5, 5'd0, 16'd16));
		emit(enc_i(OP_LW, 5'd6, 5'd0, 16'd16));
		emit(enc_i(OP_ADDI, 5'd7, 5'd6, 16'd3));
		emit(enc_i(OP_LW, 5'd8, 5'd0, 16'd8));
		emit(enc_i(OP_ADDI, 5'd9, 5'd0, 16'd1));
		emit(enc_r(FN_ADD, 5'd10, 5'd8, 5'd9));
		close_program(5'd11, 5'd10);
		run_program("load_use");

		// Taken beq skipping three and a beq not taken
		emit(enc_i(OP_ADDI, 5'd1, 5'd0, 16'd5));
		emit(enc_i(OP_ADDI, 5'd2, 5'd0, 16'd5));
		emit(enc_i(OP_ADDI, 5'd3, 5'd0, 16'd7));
		emit(enc_i(OP_BEQ, 5'd2, 5'd1, 16'd3));
		emit(enc_i(OP_ADDI, 5'd4, 5'd0, 16'd1));
		emit(enc_i(OP_ADDI, 5'd5, 5'd0, 16'd2));
		emit(enc_i(OP_ADDI, 5'd6, 5'd0, 16'd3));
		emit(enc_i(OP_BEQ, 5'd3, 5'd1, 16'd1));
		emit(enc_i(OP_ADDI, 5'd7, 5'd0, rand16()));
		emit(enc_r(FN_ADD, 5'd8, 5'd7, 5'd1));
		close_program(5'd9, 5'd8);
		run_program("branch");

		// Jump over two instructions
		emit(enc_i(OP_ADDI, 5'd1, 5'd0, rand16()));
		emit(enc_j(4));
		emit(enc_i(OP_ADDI, 5'd2, 5'd0, 16'd1));
		emit(enc_i(OP_ADDI, 5'd3, 5'd0, 16'd2));
		emit(enc_i(OP_ADDI, 5'd4, 5'd1, 16'd1));
		emit(enc_r(FN_ADD, 5'd5, 5'd4, 5'd1));
		close_program(5'd6, 5'd5);
		run_program("jump");

		// Writes to r0 are dropped
		emit(enc_i(OP_ADDI, 5'd0, 5'd0, rand16()));
		emit(enc_i(OP_ADDI, 5'd1, 5'd0, rand16()));
		emit(enc_r(FN_ADD, 5'd0, 5'd1, 5'd1));
		emit(enc_r(FN_ADD, 5'd2, 5'd0, 5'd1));
		emit(enc_i(OP_SW, 5'd1, 5'd0, 16'd20));
		emit(enc_i(OP_LW, 5'd0, 5'd0, 16'd20));
		emit(enc_r(FN_ADD, 5'd3, 5'd0, 5'd0));
		close_program(5'd4, 5'd3);
		run_program("reg_zero");

		$display("tests %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
